// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_controller
FILELIST  ?= controller.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	elif ! grep -q "Done: no errors" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: aluDecoder.sv
`timescale 1ns/1ns
module aluDecoder (
  input  logic                dpOp,
  input  armCtrlPkg::dpOpcode aluControl,
  input  logic                carryFlag,
  output armCtrlPkg::aluOp    aluOperation,
  output logic                invertB,
  output logic                reverseInputs,
  output logic                carryIn,
  output logic                cvUpdate,
  output logic                noRegWrite
);
  import armCtrlPkg::*;

  // Subtraction is A + ~B + 1, borrow forms use C as the +1
  always_comb begin
    aluOperation  = ALU_ADD;               // Plain add when no opcode
    invertB       = 1'b0;
    reverseInputs = 1'b0;
    carryIn       = 1'b0;
    cvUpdate      = 1'b0;
    noRegWrite    = 1'b0;
    if (dpOp) begin
      case (aluControl)
        AND: aluOperation = ALU_AND;
        EOR: aluOperation = ALU_EOR;
        ORR: aluOperation = ALU_ORR;
        MOV: aluOperation = ALU_PASSB;
        TST: begin
          aluOperation = ALU_AND;
          noRegWrite   = 1'b1;
        end
        TEQ: begin
          aluOperation = ALU_EOR;
          noRegWrite   = 1'b1;
        end
        BIC: begin
          aluOperation = ALU_AND;
          invertB      = 1'b1;             // A & ~B
        end
        MVN: begin
          aluOperation = ALU_PASSB;
          invertB      = 1'b1;
        end
        // Arithmetic group, all update C and V
        ADD: cvUpdate = 1'b1;
        CMN: begin
          cvUpdate   = 1'b1;
          noRegWrite = 1'b1;
        end
        ADC: begin
          carryIn  = carryFlag;
          cvUpdate = 1'b1;
        end
        SUB, CMP: begin
          invertB    = 1'b1;
          carryIn    = 1'b1;
          cvUpdate   = 1'b1;
          noRegWrite = (aluControl == CMP);
        end
        SBC: begin
          invertB  = 1'b1;
          carryIn  = carryFlag;            // Borrow is ~C
          cvUpdate = 1'b1;
        end
        RSB, RSC: begin
          reverseInputs = 1'b1;            // B - A
          invertB       = 1'b1;
          carryIn       = (aluControl == RSB) ? 1'b1 : carryFlag;
          cvUpdate      = 1'b1;
        end
      endcase
    end
  end

endmodule

// File: armCtrlPkg.sv
package armCtrlPkg;

  // ========================================
  // Widths and small types
  // ========================================
  localparam int instrW = 32;              // ARM instruction word

  typedef struct packed {
    logic n;                               // Negative
    logic z;                               // Zero
    logic c;                               // Carry
    logic v;                               // Overflow
  } nzcvT;

  typedef struct packed {
    logic nz;                              // Update N and Z
    logic cv;                              // Update C and V
  } flagWriteT;

  typedef logic [3:0] byteMaskT;           // One bit per byte lane
  typedef logic [1:0] regSrcT;             // Register file read port select
  typedef logic [1:0] immSrcT;             // Immediate extend select

  // Datapath select codes
  localparam regSrcT regSrcNormal = 2'b00; // Rn, Rm
  localparam regSrcT regSrcBranch = 2'b01; // PC on port 1
  localparam regSrcT regSrcStore  = 2'b10; // Rd on port 2 for store data
  localparam immSrcT immSrcDp     = 2'b00; // 8-bit rotated immediate
  localparam immSrcT immSrcMem    = 2'b01; // 12-bit offset
  localparam immSrcT immSrcBranch = 2'b10; // 24-bit word offset

  // ========================================
  // Enums
  // ========================================
  // Data-processing opcode, instr[24:21]
  typedef enum logic [3:0] {
    AND, EOR, SUB, RSB,
    ADD, ADC, SBC, RSC,
    TST, TEQ, CMP, CMN,
    ORR, MOV, BIC, MVN
  } dpOpcode;

  // Condition field, instr[31:28]
  typedef enum logic [3:0] {
    EQ, NE, CS, CC,
    MI, PL, VS, VC,
    HI, LS, GE, LT,
    GT, LE, AL, NV
  } condCode;

  // Operation of the ALU unit itself
  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_AND   = 3'd1,
    ALU_ORR   = 3'd2,
    ALU_EOR   = 3'd3,
    ALU_PASSB = 3'd4
  } aluOp;

  typedef enum logic [2:0] {
    DPREG     = 3'd0,
    DPIMM     = 3'd1,
    LOADSTORE = 3'd2,
    BRANCH    = 3'd3,
    NONE      = 3'd4                       // Anything not handled, no writes
  } instrClass;

endpackage

// File: condCheck.sv
`timescale 1ns/1ns
module condCheck (
  input  armCtrlPkg::condCode   cond,
  input  armCtrlPkg::nzcvT      flags,
  input  armCtrlPkg::nzcvT      aluFlags,
  input  armCtrlPkg::flagWriteT flagWrite,
  input  logic                  cvUpdate,
  output logic                  condEx,
  output armCtrlPkg::nzcvT      flagsNext
);
  import armCtrlPkg::*;

  logic signedGe;                          // N equals V

  assign signedGe = (flags.n == flags.v);

  // ========================================
  // ARM condition table
  // ========================================
  always_comb begin
    case (cond)
      EQ: condEx = flags.z;
      NE: condEx = ~flags.z;
      CS: condEx = flags.c;
      CC: condEx = ~flags.c;
      MI: condEx = flags.n;
      PL: condEx = ~flags.n;
      VS: condEx = flags.v;
      VC: condEx = ~flags.v;
      HI: condEx = flags.c & ~flags.z;     // Unsigned higher
      LS: condEx = ~flags.c | flags.z;
      GE: condEx = signedGe;
      LT: condEx = ~signedGe;
      GT: condEx = ~flags.z & signedGe;
      LE: condEx = flags.z | ~signedGe;
      AL: condEx = 1'b1;
      NV: condEx = 1'b0;                   // Never
    endcase
  end

  // Next flags, untouched bits keep the current value
  always_comb begin
    flagsNext = flags;
    if (flagWrite.nz) begin
      flagsNext.n = aluFlags.n;
      flagsNext.z = aluFlags.z;
    end
    if (flagWrite.cv && cvUpdate) begin    // Logical ops leave C and V
      flagsNext.c = aluFlags.c;
      flagsNext.v = aluFlags.v;
    end
  end

endmodule

// File: controller.f
armCtrlPkg.sv
decodeIf.sv
instrDecoder.sv
aluDecoder.sv
condCheck.sv
psrFlags.sv
controller.sv
tb_controller.sv

// File: controller.sv
`timescale 1ns/1ns
module controller (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic [armCtrlPkg::instrW-1:0] instrD,
  input  armCtrlPkg::nzcvT              aluFlagsE,
  input  logic [31:0]                   aluResultE,
  input  logic                          stallE,
  input  logic                          stallM,
  input  logic                          stallW,
  input  logic                          flushE,
  input  logic                          flushM,
  input  logic                          flushW,
  output armCtrlPkg::regSrcT            regSrcD,
  output armCtrlPkg::immSrcT            immSrcD,
  output logic                          aluSrcE,
  output armCtrlPkg::aluOp              aluOperationE,
  output logic                          invertBE,
  output logic                          aluCarryInE,
  output logic                          branchTakenE,
  output armCtrlPkg::nzcvT              flagsE,
  output logic                          memWriteM,
  output armCtrlPkg::byteMaskT          byteMaskM,
  output logic                          memToRegW,
  output logic                          regWriteW,
  output logic                          pcSrcW,
  output logic                          pcWrPendingF
);
  import armCtrlPkg::*;

  // Stage register contents
  typedef struct packed {
    logic      regWrite;
    logic      memWrite;
    logic      memToReg;
    logic      branch;
    logic      pcSrc;
    logic      aluSrc;
    logic      dpOp;
    logic      byteAccess;
    flagWriteT flagWrite;
    dpOpcode   aluControl;
    condCode   cond;
  } exStageT;

  typedef struct packed {
    logic     regWrite;
    logic     memWrite;
    logic     memToReg;
    logic     pcSrc;
    logic     setFlags;
    byteMaskT byteMask;
    nzcvT     flagsNext;
  } memStageT;

  typedef struct packed {
    logic regWrite;
    logic memToReg;
    logic pcSrc;
    logic setFlags;
    nzcvT flagsNext;
  } wbStageT;

  decodeIf  decBus ();
  exStageT  exNext, exReg;
  memStageT memNext, memReg;
  wbStageT  wbNext, wbReg;
  logic     condExE;
  logic     cvUpdateE;
  logic     noRegWriteE;
  nzcvT     flagsNextE;

  // ========================================
  // Decode
  // ========================================
  instrDecoder instrDecoder_i (
    .instrD  (instrD),
    .dec     (decBus),
    .regSrcD (regSrcD),
    .immSrcD (immSrcD)
  );

  always_comb begin
    exNext.regWrite   = decBus.regWrite;
    exNext.memWrite   = decBus.memWrite;
    exNext.memToReg   = decBus.memToReg;
    exNext.branch     = decBus.branch;
    exNext.pcSrc      = decBus.pcSrc;
    exNext.aluSrc     = decBus.aluSrc;
    exNext.dpOp       = decBus.dpOp;
    exNext.byteAccess = decBus.byteAccess;
    exNext.flagWrite  = decBus.flagWrite;
    exNext.aluControl = decBus.aluControl;
    exNext.cond       = decBus.cond;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exReg <= '0;
    end else if (flushE) begin
      exReg <= '0;                         // Bubble
    end else if (!stallE) begin
      exReg <= exNext;
    end
  end

  // ========================================
  // Execute
  // ========================================
  aluDecoder aluDecoder_i (
    .dpOp          (exReg.dpOp),
    .aluControl    (exReg.aluControl),
    .carryFlag     (flagsE.c),             // Forwarded C
    .aluOperation  (aluOperationE),
    .invertB       (invertBE),
    .reverseInputs (),
    .carryIn       (aluCarryInE),
    .cvUpdate      (cvUpdateE),
    .noRegWrite    (noRegWriteE)
  );

  condCheck condCheck_i (
    .cond      (exReg.cond),
    .flags     (flagsE),
    .aluFlags  (aluFlagsE),
    .flagWrite (exReg.flagWrite),
    .cvUpdate  (cvUpdateE),
    .condEx    (condExE),
    .flagsNext (flagsNextE)
  );

  assign aluSrcE      = exReg.aluSrc;
  assign branchTakenE = exReg.branch & condExE;

  // Gate everything by the condition outcome
  always_comb begin
    memNext.regWrite  = exReg.regWrite & condExE & ~noRegWriteE; // Compares write flags only
    memNext.memWrite  = exReg.memWrite & condExE;
    memNext.memToReg  = exReg.memToReg & condExE;
    memNext.pcSrc     = exReg.pcSrc & condExE & ~noRegWriteE;
    memNext.setFlags  = (exReg.flagWrite.nz | exReg.flagWrite.cv) & condExE;
    memNext.flagsNext = flagsNextE;
    if (!memNext.memWrite) begin
      memNext.byteMask = '0;
    end else if (exReg.byteAccess) begin
      memNext.byteMask = byteMaskT'(4'b0001 << aluResultE[1:0]); // Lane from address
    end else begin
      memNext.byteMask = '1;               // Word store
    end
  end

  // ========================================
  // Memory and Writeback
  // ========================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memReg <= '0;
    end else if (flushM) begin
      memReg <= '0;
    end else if (!stallM) begin
      memReg <= memNext;
    end
  end

  assign memWriteM = memReg.memWrite;
  assign byteMaskM = memReg.byteMask;

  always_comb begin
    wbNext.regWrite  = memReg.regWrite;
    wbNext.memToReg  = memReg.memToReg;
    wbNext.pcSrc     = memReg.pcSrc;
    wbNext.setFlags  = memReg.setFlags;
    wbNext.flagsNext = memReg.flagsNext;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbReg <= '0;
    end else if (flushW) begin
      wbReg <= '0;
    end else if (!stallW) begin
      wbReg <= wbNext;
    end
  end

  assign memToRegW = wbReg.memToReg;
  assign regWriteW = wbReg.regWrite;
  assign pcSrcW    = wbReg.pcSrc;

  // NZCV with forwarding back to Execute
  psrFlags psrFlags_i (
    .clk        (clk),
    .arstN      (arstN),
    .flagsNextM (memReg.flagsNext),
    .setFlagsM  (memReg.setFlags),
    .flagsNextW (wbReg.flagsNext),
    .setFlagsW  (wbReg.setFlags),
    .stallW     (stallW),
    .flagsE     (flagsE)
  );

  // Fetch holds off while a PC write is in flight
  assign pcWrPendingF = decBus.pcSrc | exReg.pcSrc | memReg.pcSrc;

endmodule

// File: decodeIf.sv
`timescale 1ns/1ns
interface decodeIf;
  import armCtrlPkg::*;

  // Decode-stage control bundle, all combinational from instrD
  logic      aluSrc;                       // Immediate as operand B
  logic      memToReg;                     // Load result to register file
  logic      regWrite;
  logic      memWrite;
  logic      branch;
  logic      pcSrc;                        // Writes the PC
  dpOpcode   aluControl;
  flagWriteT flagWrite;
  logic      byteAccess;                   // LDRB or STRB
  logic      dpOp;                         // aluControl is meaningful
  condCode   cond;

  // Decoder side
  modport dec (
    output aluSrc, memToReg, regWrite, memWrite, branch, pcSrc,
    output aluControl, flagWrite, byteAccess, dpOp, cond
  );

  // Pipeline side
  modport pipe (
    input aluSrc, memToReg, regWrite, memWrite, branch, pcSrc,
    input aluControl, flagWrite, byteAccess, dpOp, cond
  );

endinterface

// File: instrDecoder.sv
`timescale 1ns/1ns
module instrDecoder (
  input  logic [armCtrlPkg::instrW-1:0] instrD,
  decodeIf.dec                          dec,
  output armCtrlPkg::regSrcT            regSrcD,
  output armCtrlPkg::immSrcT            immSrcD
);
  import armCtrlPkg::*;

  instrClass cls;
  logic      miscSpace;                    // Compare opcodes without S
  logic      mulSpace;                     // Multiply and halfword encodings
  logic      sBit;
  logic      lBit;
  logic      upBit;
  logic      rdIsPc;

  assign sBit   = instrD[20];
  assign lBit   = instrD[20];              // Load when set
  assign upBit  = instrD[23];              // Add offset when set
  assign rdIsPc = (instrD[15:12] == 4'hF);

  // TST..CMN with S clear is the MRS/MSR/BX group
  assign miscSpace = (instrD[24:23] == 2'b10) & ~sBit;
  assign mulSpace  = instrD[7] & instrD[4];

  // ========================================
  // Classification on bits 27:25
  // ========================================
  always_comb begin
    case (instrD[27:25])
      3'b000:  cls = (miscSpace | mulSpace) ? NONE : DPREG;
      3'b001:  cls = miscSpace ? NONE : DPIMM;
      3'b010:  cls = LOADSTORE;            // Immediate offset
      3'b011:  cls = instrD[4] ? NONE : LOADSTORE; // Bit 4 set is media space
      3'b101:  cls = instrD[24] ? NONE : BRANCH;   // BL not handled
      default: cls = NONE;                 // LDM/STM, coprocessor, SWI
    endcase
  end

  // ========================================
  // Control bundle per class
  // ========================================
  always_comb begin
    regSrcD          = regSrcNormal;
    immSrcD          = immSrcDp;
    dec.aluSrc       = 1'b0;
    dec.memToReg     = 1'b0;
    dec.regWrite     = 1'b0;
    dec.memWrite     = 1'b0;
    dec.branch       = 1'b0;
    dec.aluControl   = ADD;                // Address and branch target add
    dec.flagWrite.nz = 1'b0;
    dec.flagWrite.cv = 1'b0;
    dec.byteAccess   = 1'b0;
    dec.dpOp         = 1'b0;
    case (cls)
      DPREG, DPIMM: begin
        dec.aluSrc       = (cls == DPIMM);
        dec.regWrite     = 1'b1;           // Compares dropped later in Execute
        dec.dpOp         = 1'b1;
        dec.aluControl   = dpOpcode'(instrD[24:21]);
        dec.flagWrite.nz = sBit;
        dec.flagWrite.cv = sBit;           // Logical ops masked by cvUpdate
      end
      LOADSTORE: begin
        immSrcD        = immSrcMem;
        dec.aluSrc     = ~instrD[25];      // I bit clear means immediate offset
        dec.dpOp       = 1'b1;
        dec.aluControl = upBit ? ADD : SUB;
        dec.byteAccess = instrD[22];
        if (lBit) begin
          dec.memToReg = 1'b1;
          dec.regWrite = 1'b1;
        end else begin
          regSrcD      = regSrcStore;      // Store data from Rd
          dec.memWrite = 1'b1;
        end
      end
      BRANCH: begin
        regSrcD    = regSrcBranch;
        immSrcD    = immSrcBranch;
        dec.aluSrc = 1'b1;                 // PC plus offset
        dec.branch = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign dec.pcSrc = (rdIsPc & dec.regWrite) | dec.branch; // Any PC write
  assign dec.cond  = condCode'(instrD[31:28]);

endmodule

// File: psrFlags.sv
`timescale 1ns/1ns
module psrFlags (
  input  logic             clk,
  input  logic             arstN,
  input  armCtrlPkg::nzcvT flagsNextM,
  input  logic             setFlagsM,
  input  armCtrlPkg::nzcvT flagsNextW,
  input  logic             setFlagsW,
  input  logic             stallW,
  output armCtrlPkg::nzcvT flagsE
);
  import armCtrlPkg::*;

  nzcvT nzcv;                              // Committed flags

  // Commit from Writeback once the stage moves on
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      nzcv <= '0;
    end else if (!stallW && setFlagsW) begin
      nzcv <= flagsNextW;
    end
  end

  // Youngest flag-setting instruction wins
  always_comb begin
    if (setFlagsM) begin
      flagsE = flagsNextM;                 // Instruction just ahead of Execute
    end else if (setFlagsW) begin
      flagsE = flagsNextW;                 // Not yet committed
    end else begin
      flagsE = nzcv;
    end
  end

endmodule

// File: tb_controller.sv
`timescale 1ns/1ns
module tb_controller;
  import armCtrlPkg::*;

  // ========================================
  // Run constants
  // ========================================
  localparam int seed        = 73;
  localparam int halfPeriod  = 50;         // 100 ns clock
  localparam int driveDelay  = 5;          // After the rising edge
  localparam int drainCycles = 5;
  localparam int condReps    = 3;
  localparam int flagRounds  = 24;
  localparam int testCycles  = 3 + 6 * drainCycles + 6 + 16 * condReps * 4 + flagRounds
                               + 16 * 2 * 2 + 10 + 21;
  localparam int timeoutLimit = testCycles + 50;
  localparam logic [31:0] nopInstr = 32'hF000_0000; // ANDNV, never writes
  localparam logic [3:0]  condAl   = 4'hE;

  logic              clk = 1'b0;
  logic              arstN;
  logic [instrW-1:0] instrD;
  nzcvT              aluFlagsE;
  logic [31:0]       aluResultE;
  logic              stallE, stallM, stallW;
  logic              flushE, flushM, flushW;
  regSrcT            regSrcD;
  immSrcT            immSrcD;
  logic              aluSrcE, invertBE, aluCarryInE, branchTakenE;
  aluOp              aluOperationE;
  nzcvT              flagsE;
  logic              memWriteM;
  byteMaskT          byteMaskM;
  logic              memToRegW, regWriteW, pcSrcW, pcWrPendingF;

  int errorCount      = 0;
  int testCount       = 0;
  int testStartErrors = 0;
  int cycleCount      = 0;

  always #halfPeriod clk = ~clk;

  controller controller_i (
    .clk(clk), .arstN(arstN), .instrD(instrD), .aluFlagsE(aluFlagsE),
    .aluResultE(aluResultE), .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushE(flushE), .flushM(flushM), .flushW(flushW), .regSrcD(regSrcD),
    .immSrcD(immSrcD), .aluSrcE(aluSrcE), .aluOperationE(aluOperationE),
    .invertBE(invertBE), .aluCarryInE(aluCarryInE), .branchTakenE(branchTakenE),
    .flagsE(flagsE), .memWriteM(memWriteM), .byteMaskM(byteMaskM),
    .memToRegW(memToRegW), .regWriteW(regWriteW), .pcSrcW(pcSrcW),
    .pcWrPendingF(pcWrPendingF)
  );

  // ========================================
  // Reference model
  // ========================================
  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       memToReg;
    logic       branch;
    logic       pcSrc;
    logic       aluSrc;
    logic       dpOp;
    logic       byteAccess;
    logic       setNz;
    logic       setCv;
    logic [3:0] opc;
    logic [3:0] cond;
    regSrcT     regSrc;
    immSrcT     immSrc;
  } ctrlT;

  typedef struct packed {
    aluOp op;
    logic invB;
    logic cin;
    logic arith;                           // Updates C and V
    logic noRw;                            // Compare, flags only
  } aluCtrlT;

  // Memory and Writeback contents, W ignores memWrite and mask
  typedef struct packed {
    logic     regWrite;
    logic     memWrite;
    logic     memToReg;
    logic     pcSrc;
    logic     setFlags;
    byteMaskT mask;
    nzcvT     flags;
  } lateT;

  function automatic ctrlT decodeRef(input logic [31:0] ins);
    ctrlT r;
    r      = '0;
    r.cond = ins[31:28];
    case (ins[27:25])
      3'b000, 3'b001: begin                // Data processing
        r.aluSrc   = ins[25];
        r.regWrite = 1'b1;
        r.dpOp     = 1'b1;
        r.opc      = ins[24:21];
        r.setNz    = ins[20];
        r.setCv    = ins[20];
      end
      3'b010: begin                        // LDR/STR, immediate offset
        r.immSrc     = immSrcMem;
        r.aluSrc     = 1'b1;
        r.dpOp       = 1'b1;
        r.opc        = ins[23] ? 4'd4 : 4'd2; // ADD or SUB by U
        r.byteAccess = ins[22];
        r.memToReg   = ins[20];
        r.regWrite   = ins[20];
        r.memWrite   = ~ins[20];
        r.regSrc     = ins[20] ? regSrcNormal : regSrcStore;
      end
      3'b101: begin
        if (!ins[24]) begin                // Plain B only
          r.regSrc = regSrcBranch;
          r.immSrc = immSrcBranch;
          r.aluSrc = 1'b1;
          r.branch = 1'b1;
        end
      end
      default: begin
      end
    endcase
    r.pcSrc = r.branch | (r.regWrite & (ins[15:12] == 4'hF));
    return r;
  endfunction

  // Even codes test a condition, odd codes its opposite
  function automatic logic condRef(input logic [3:0] cond, input nzcvT f);
    logic base;
    case (cond[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c & ~f.z;
      3'd5:    base = (f.n == f.v);
      3'd6:    base = ~f.z & (f.n == f.v);
      default: base = 1'b1;                // AL, and NV once inverted
    endcase
    return base ^ cond[0];
  endfunction

  function automatic aluCtrlT aluRef(input logic dpOp, input logic [3:0] opc, input logic c);
    aluCtrlT r;
    r    = '0;
    r.op = ALU_ADD;
    if (dpOp) begin
      case (dpOpcode'(opc))
        AND, TST: r.op = ALU_AND;
        EOR, TEQ: r.op = ALU_EOR;
        ORR:      r.op = ALU_ORR;
        MOV:      r.op = ALU_PASSB;
        BIC: begin
          r.op   = ALU_AND;
          r.invB = 1'b1;
        end
        MVN: begin
          r.op   = ALU_PASSB;
          r.invB = 1'b1;
        end
        ADD, CMN: r.arith = 1'b1;
        ADC: begin
          r.cin   = c;
          r.arith = 1'b1;
        end
        SUB, CMP, RSB: begin               // Two's complement subtract
          r.invB  = 1'b1;
          r.cin   = 1'b1;
          r.arith = 1'b1;
        end
        SBC, RSC: begin
          r.invB  = 1'b1;
          r.cin   = c;
          r.arith = 1'b1;
        end
      endcase
      r.noRw = (opc[3:2] == 2'b10);        // TST TEQ CMP CMN
    end
    return r;
  endfunction

  ctrlT    exM;
  lateT    memM, wbM, memNextExp;
  nzcvT    nzcvM, flagsExp;
  ctrlT    decExp;
  aluCtrlT aluExp;
  logic    condExp, branchExp, pendingExp;

  always_comb begin
    decExp   = decodeRef(instrD);
    flagsExp = memM.setFlags ? memM.flags : (wbM.setFlags ? wbM.flags : nzcvM);
    condExp  = condRef(exM.cond, flagsExp);
    aluExp   = aluRef(exM.dpOp, exM.opc, flagsExp.c);
    memNextExp.flags = flagsExp;
    if (exM.setNz) begin
      memNextExp.flags.n = aluFlagsE.n;
      memNextExp.flags.z = aluFlagsE.z;
    end
    if (exM.setCv && aluExp.arith) begin   // Logical ops keep C and V
      memNextExp.flags.c = aluFlagsE.c;
      memNextExp.flags.v = aluFlagsE.v;
    end
    memNextExp.regWrite = exM.regWrite & condExp & ~aluExp.noRw;
    memNextExp.memWrite = exM.memWrite & condExp;
    memNextExp.memToReg = exM.memToReg & condExp;
    memNextExp.pcSrc    = exM.pcSrc & condExp & ~aluExp.noRw;
    memNextExp.setFlags = (exM.setNz | exM.setCv) & condExp;
    memNextExp.mask     = 4'b0000;
    if (memNextExp.memWrite && exM.byteAccess) begin
      memNextExp.mask[aluResultE[1:0]] = 1'b1; // Lane of the byte address
    end else if (memNextExp.memWrite) begin
      memNextExp.mask = 4'b1111;
    end
    branchExp  = exM.branch & condExp;
    pendingExp = decExp.pcSrc | exM.pcSrc | memM.pcSrc;
  end

  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exM   <= '0;
      memM  <= '0;
      wbM   <= '0;
      nzcvM <= '0;
    end else begin
      if (flushE) exM <= '0;
      else if (!stallE) exM <= decExp;
      if (flushM) memM <= '0;
      else if (!stallM) memM <= memNextExp;
      if (flushW) wbM <= '0;
      else if (!stallW) wbM <= memM;
      if (!stallW && wbM.setFlags) nzcvM <= wbM.flags; // Commit in W
    end
  end

  // ========================================
  // Output checks
  // ========================================
  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
    errorCount++;
    $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, want, $time);
  endtask

  regSrcOk: assert property (@(posedge clk) disable iff (!arstN) regSrcD == decExp.regSrc)
    else mismatch("regSrcD", 32'($sampled(regSrcD)), 32'($sampled(decExp.regSrc)));
  immSrcOk: assert property (@(posedge clk) disable iff (!arstN) immSrcD == decExp.immSrc)
    else mismatch("immSrcD", 32'($sampled(immSrcD)), 32'($sampled(decExp.immSrc)));
  aluSrcOk: assert property (@(posedge clk) disable iff (!arstN) aluSrcE == exM.aluSrc)
    else mismatch("aluSrcE", 32'($sampled(aluSrcE)), 32'($sampled(exM.aluSrc)));
  aluOpOk: assert property (@(posedge clk) disable iff (!arstN) aluOperationE == aluExp.op)
    else mismatch("aluOperationE", 32'($sampled(aluOperationE)), 32'($sampled(aluExp.op)));
  invertOk: assert property (@(posedge clk) disable iff (!arstN) invertBE == aluExp.invB)
    else mismatch("invertBE", 32'($sampled(invertBE)), 32'($sampled(aluExp.invB)));
  carryOk: assert property (@(posedge clk) disable iff (!arstN) aluCarryInE == aluExp.cin)
    else mismatch("aluCarryInE", 32'($sampled(aluCarryInE)), 32'($sampled(aluExp.cin)));
  branchOk: assert property (@(posedge clk) disable iff (!arstN) branchTakenE == branchExp)
    else mismatch("branchTakenE", 32'($sampled(branchTakenE)), 32'($sampled(branchExp)));
  flagsOk: assert property (@(posedge clk) disable iff (!arstN) flagsE == flagsExp)
    else mismatch("flagsE", 32'($sampled(flagsE)), 32'($sampled(flagsExp)));
  memWriteOk: assert property (@(posedge clk) disable iff (!arstN) memWriteM == memM.memWrite)
    else mismatch("memWriteM", 32'($sampled(memWriteM)), 32'($sampled(memM.memWrite)));
  maskOk: assert property (@(posedge clk) disable iff (!arstN) byteMaskM == memM.mask)
    else mismatch("byteMaskM", 32'($sampled(byteMaskM)), 32'($sampled(memM.mask)));
  memToRegOk: assert property (@(posedge clk) disable iff (!arstN) memToRegW == wbM.memToReg)
    else mismatch("memToRegW", 32'($sampled(memToRegW)), 32'($sampled(wbM.memToReg)));
  regWriteOk: assert property (@(posedge clk) disable iff (!arstN) regWriteW == wbM.regWrite)
    else mismatch("regWriteW", 32'($sampled(regWriteW)), 32'($sampled(wbM.regWrite)));
  pcSrcOk: assert property (@(posedge clk) disable iff (!arstN) pcSrcW == wbM.pcSrc)
    else mismatch("pcSrcW", 32'($sampled(pcSrcW)), 32'($sampled(wbM.pcSrc)));
  pendingOk: assert property (@(posedge clk) disable iff (!arstN) pcWrPendingF == pendingExp)
    else mismatch("pcWrPendingF", 32'($sampled(pcWrPendingF)), 32'($sampled(pendingExp)));

  // ========================================
  // Encoders and stimulus
  // ========================================
  function automatic logic [31:0] dpReg(input logic [3:0] cond, input logic [3:0] opc,
                                        input logic s, input logic [3:0] rd);
    return {cond, 3'b000, opc, s, 4'd2, rd, 8'h00, 4'd3}; // Rn r2, Rm r3
  endfunction

  function automatic logic [31:0] dpImm(input logic [3:0] cond, input logic [3:0] opc,
                                        input logic s, input logic [3:0] rd);
    return {cond, 3'b001, opc, s, 4'd2, rd, 4'h0, 8'h2A};
  endfunction

  function automatic logic [31:0] memOp(input logic [3:0] cond, input logic load,
                                        input logic byteOp, input logic up);
    return {cond, 3'b010, 1'b1, up, byteOp, 1'b0, load, 4'd6, 4'd5, 12'h004};
  endfunction

  function automatic logic [31:0] branchTo(input logic [3:0] cond);
    return {cond, 3'b101, 1'b0, 24'h000040};
  endfunction

  // One instruction per cycle, fresh ALU flags and result
  task automatic issue(input logic [31:0] instr);
    logic [31:0] rnd;
    @(posedge clk);
    #driveDelay;
    rnd        = $urandom();
    instrD     = instr;
    aluFlagsE  = rnd[3:0];
    aluResultE = $urandom();
  endtask

  task automatic finishTest(input string name);
    repeat (drainCycles) issue(nopInstr);
    testCount++;
    $display("Test %0d %s: %0d errors", testCount, name, errorCount - testStartErrors);
    testStartErrors = errorCount;
  endtask

  // ========================================
  // Tests
  // ========================================
  task automatic classDecode();
    issue(dpReg(condAl, ADD, 1'b0, 4'd1));
    issue(dpImm(condAl, MOV, 1'b0, 4'd4));
    issue(memOp(condAl, 1'b1, 1'b0, 1'b1));  // LDR
    issue(memOp(condAl, 1'b0, 1'b0, 1'b0));  // STR, negative offset
    issue(branchTo(condAl));
    issue(dpReg(condAl, MOV, 1'b0, 4'd15));  // MOV pc
    finishTest("class decode");
  endtask

  task automatic condGating();
    for (int c = 0; c < 16; c++) begin
      repeat (condReps) begin
        issue(dpReg(condAl, ADD, 1'b1, 4'd1)); // ADDS loads random flags
        issue(branchTo(4'(c)));
        issue(memOp(4'(c), 1'b0, 1'b0, 1'b1));
        issue(dpReg(4'(c), ADD, 1'b0, 4'd7));
      end
    end
    finishTest("condition gating");
  endtask

  task automatic flagForward();
    logic [3:0] opc;
    logic [3:0] rd;
    repeat (flagRounds) begin
      opc = 4'($urandom_range(15, 0));
      rd  = 4'($urandom_range(14, 0));
      if ($urandom_range(1, 0) == 1) issue(dpImm(condAl, opc, 1'b1, rd));
      else issue(dpReg(condAl, opc, 1'b1, rd));
    end
    finishTest("flag forwarding");
  endtask

  task automatic aluControl();
    for (int op = 0; op < 16; op++) begin
      for (int k = 0; k < 2; k++) begin
        issue(dpReg(condAl, ADD, 1'b1, 4'd1));
        issue(dpReg(condAl, 4'(op), 1'b1, 4'd8));
        aluFlagsE.c = k[0];                 // C the op will see
      end
    end
    finishTest("ALU control");
  endtask

  task automatic byteMask();
    for (int lane = 0; lane < 4; lane++) begin
      issue(memOp(condAl, 1'b0, 1'b1, 1'b1)); // STRB
      issue(nopInstr);
      aluResultE[1:0] = lane[1:0];
    end
    issue(memOp(condAl, 1'b0, 1'b0, 1'b1));  // Word store
    issue(memOp(condAl, 1'b1, 1'b1, 1'b1));  // LDRB, no mask
    finishTest("byte mask");
  endtask

  task automatic stallFlush();
    issue(dpReg(condAl, ADD, 1'b1, 4'd1));
    issue(branchTo(condAl));
    stallE = 1'b1;                         // ADDS held in Execute
    flushM = 1'b1;
    issue(branchTo(condAl));
    issue(branchTo(condAl));
    stallE = 1'b0;
    flushM = 1'b0;
    repeat (3) issue(nopInstr);            // B walks through E and M
    issue(branchTo(condAl));
    flushE = 1'b1;                         // B dropped before Execute
    issue(nopInstr);
    flushE = 1'b0;
    issue(memOp(condAl, 1'b0, 1'b0, 1'b1));
    issue(nopInstr);
    flushM = 1'b1;                         // STR gone before Memory
    issue(nopInstr);
    flushM = 1'b0;
    issue(memOp(condAl, 1'b1, 1'b0, 1'b1));
    repeat (2) issue(nopInstr);
    flushW = 1'b1;                         // LDR gone before Writeback
    issue(nopInstr);
    flushW = 1'b0;
    issue(dpReg(condAl, ADD, 1'b1, 4'd1));
    repeat (2) issue(nopInstr);
    stallE = 1'b1;                         // Whole back end frozen
    stallM = 1'b1;
    stallW = 1'b1;
    issue(nopInstr);
    stallE = 1'b0;
    stallM = 1'b0;
    stallW = 1'b0;
    issue(nopInstr);
    finishTest("stall and flush");
  endtask

  // Hung-run guard
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutLimit) begin
      $display("Timeout: tests still running after %0d cycles", timeoutLimit);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    void'($urandom(seed));
    arstN      = 1'b0;
    instrD     = nopInstr;
    aluFlagsE  = '0;
    aluResultE = '0;
    stallE     = 1'b0;
    stallM     = 1'b0;
    stallW     = 1'b0;
    flushE     = 1'b0;
    flushM     = 1'b0;
    flushW     = 1'b0;
    repeat (2) @(posedge clk);
    #driveDelay;
    arstN = 1'b1;
    classDecode();
    condGating();
    flagForward();
    aluControl();
    byteMask();
    stallFlush();
    $display("Tests run: %0d, errors: %0d", testCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
